//--- Makefile
# Verilator build and run of the fetch front end testbench

VERILATOR ?= verilator
TOP       ?= tb_ifu
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only when the pass line shows up in the simulation output
run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF -- '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- fetch_pc_gen.sv
`include "ifu_params.svh"

module fetch_pc_gen (
  input  logic                 core_clock_i,
  input  logic                 core_reset_i,
  input  logic                 redirect_i,
  input  logic [`IFU_PC_W-1:0] redirect_pc_i,
  input  logic                 busy_i,
  output ifu_pkg::fetch_req_t  fetch_req_o
);

  logic [`IFU_PC_W-1:0] pc_q;
  logic [`IFU_PC_W-1:0] pc_step;
  logic                 run_q;

  // odd word only has one instruction left in its 64-bit slot
  assign pc_step = pc_q[0] ? `IFU_PC_W'd1 : `IFU_PC_W'd2;

  // redirect outranks the cache busy level
  always_ff @(posedge core_clock_i) begin
    if (core_reset_i) begin
      pc_q <= `IFU_RESET_PC;
    end else if (redirect_i) begin
      pc_q <= redirect_pc_i;
    end else if (!busy_i) begin
      pc_q <= pc_q + pc_step;
    end
  end

  // low for the reset cycles, then stays up
  always_ff @(posedge core_clock_i) begin
    if (core_reset_i) begin
      run_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
    end
  end

  // pc is stale while a redirect is loading
  assign fetch_req_o.valid = run_q & ~redirect_i;
  assign fetch_req_o.pc    = pc_q;

  // cache stall must hold the pc until the refill or flush completes
  a_pc_hold: assert property (@(posedge core_clock_i) disable iff (core_reset_i)
    busy_i && !redirect_i |=> $stable(pc_q));

endmodule

//--- files.f
+incdir+.
ifu_pkg.sv
fetch_pc_gen.sv
icache_array.sv
icache_refill.sv
icache.sv
ifu_top.sv
tb_ifu.sv

//--- icache.sv
`include "ifu_params.svh"

module icache (
  input  logic                core_clock_i,
  input  logic                core_reset_i,
  input  ifu_pkg::fetch_req_t fetch_req_i,
  input  logic                decode_stall_i,
  output logic                busy_o,
  output ifu_pkg::fetch_pkt_t fetch_pkt_o,
  input  logic                icache_flush_i,
  output logic                flush_idle_o,
  input  logic                victim_bit_i,
  output ifu_pkg::bus_req_t   bus_req_o,
  input  logic                bus_ready_i,
  input  ifu_pkg::bus_rsp_t   bus_rsp_i
);

  localparam int DATA_DEPTH = 2 * `IFU_SETS * `IFU_LINE_WORDS;

  ifu_pkg::tag_entry_t     tag_rd [2];
  ifu_pkg::tag_entry_t     tag_wr_entry;
  ifu_pkg::refill_state_t  state;
  logic [1:0]              tag_wr;
  logic [`IFU_SET_W-1:0]   tag_wr_set;
  logic [`IFU_SET_W-1:0]   set_idx;
  logic [`IFU_TAG_W-1:0]   pc_tag;
  logic [1:0]              hit;
  logic                    miss;
  logic                    victim;
  logic                    data_wr;
  logic [`IFU_DATA_AW-1:0] data_wr_addr;
  logic [`IFU_FETCH_W-1:0] data_wr_word;
  logic [`IFU_DATA_AW-1:0] data_rd_addr;
  logic [`IFU_FETCH_W-1:0] data_rd_word;
  logic                    pkt_valid_q;
  logic [`IFU_PC_W-1:0]    pkt_pc_q;
  logic [`IFU_FETCH_W-1:0] pkt_instr_q;

  // pc split: tag, set, instruction offset
  assign set_idx = fetch_req_i.pc[`IFU_SET_W+`IFU_OFF_W-1:`IFU_OFF_W];
  assign pc_tag  = fetch_req_i.pc[`IFU_PC_W-1:`IFU_SET_W+`IFU_OFF_W];

  // one tag array per way
  for (genvar w = 0; w < 2; w++) begin : g_tag_way
    icache_array #(
      .entry_t(ifu_pkg::tag_entry_t),
      .depth  (`IFU_SETS)
    ) u_tag (
      .core_clock_i(core_clock_i),
      .wr_en_i     (tag_wr[w]),
      .wr_addr_i   (tag_wr_set),
      .wr_data_i   (tag_wr_entry),
      .rd_addr_i   (set_idx),
      .rd_data_o   (tag_rd[w])
    );
    assign hit[w] = tag_rd[w].valid && (tag_rd[w].tag == pc_tag);
  end

  // both ways share one data store, way is the top address bit
  icache_array #(
    .entry_t(logic [`IFU_FETCH_W-1:0]),
    .depth  (DATA_DEPTH)
  ) u_data (
    .core_clock_i(core_clock_i),
    .wr_en_i     (data_wr),
    .wr_addr_i   (data_wr_addr),
    .wr_data_i   (data_wr_word),
    .rd_addr_i   (data_rd_addr),
    .rd_data_o   (data_rd_word)
  );

  assign data_rd_addr = {hit[1], set_idx, fetch_req_i.pc[`IFU_OFF_W-1:1]};

  // stalled decode cannot take the line anyway
  assign miss = fetch_req_i.valid && !(|hit) && !decode_stall_i;

  // first free way, random pick when the set is full
  always_comb begin
    if (!tag_rd[0].valid) begin
      victim = 1'b0;
    end else if (!tag_rd[1].valid) begin
      victim = 1'b1;
    end else begin
      victim = victim_bit_i;
    end
  end

  icache_refill u_refill (
    .core_clock_i  (core_clock_i),
    .core_reset_i  (core_reset_i),
    .miss_i        (miss),
    .miss_pc_i     (fetch_req_i.pc),
    .victim_i      (victim),
    .icache_flush_i(icache_flush_i),
    .state_o       (state),
    .bus_req_o     (bus_req_o),
    .bus_ready_i   (bus_ready_i),
    .bus_rsp_i     (bus_rsp_i),
    .tag_wr_o      (tag_wr),
    .tag_wr_set_o  (tag_wr_set),
    .tag_wr_entry_o(tag_wr_entry),
    .data_wr_o     (data_wr),
    .data_wr_addr_o(data_wr_addr),
    .data_wr_word_o(data_wr_word)
  );

  // pc generator holds while a miss is pending or the engine runs
  assign busy_o       = (state != ifu_pkg::refill_idle) || miss;
  assign flush_idle_o = (state == ifu_pkg::refill_idle);

  // only idle lookups count, so a held pc is not sent twice
  always_ff @(posedge core_clock_i) begin
    if (core_reset_i) begin
      pkt_valid_q <= 1'b0;
    end else if (!decode_stall_i) begin
      pkt_valid_q <= fetch_req_i.valid && (|hit) && (state == ifu_pkg::refill_idle);
    end
  end

  always_ff @(posedge core_clock_i) begin
    if (!decode_stall_i) begin
      pkt_pc_q    <= fetch_req_i.pc;
      pkt_instr_q <= data_rd_word;
    end
  end

  assign fetch_pkt_o.valid = pkt_valid_q;
  assign fetch_pkt_o.pc    = pkt_pc_q;
  assign fetch_pkt_o.instr = pkt_instr_q;

  // refill only fills a way after both missed, so a line lives in one way
  a_one_way: assert property (@(posedge core_clock_i) disable iff (core_reset_i)
    state == ifu_pkg::refill_idle |-> !(hit[0] && hit[1]));

endmodule

//--- icache_array.sv
module icache_array #(
  parameter type entry_t = logic [63:0],
  parameter int  depth   = 64
) (
  input  logic                     core_clock_i,
  input  logic                     wr_en_i,
  input  logic [$clog2(depth)-1:0] wr_addr_i,
  input  entry_t                   wr_data_i,
  input  logic [$clog2(depth)-1:0] rd_addr_i,
  output entry_t                   rd_data_o
);

  // no reset, tag valid bits are cleared by the invalidate sweep
  entry_t mem_q [depth];

  // single write port
  always_ff @(posedge core_clock_i) begin
    if (wr_en_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end
  end

  // asynchronous read, lookup result in the same cycle
  assign rd_data_o = mem_q[rd_addr_i];

endmodule

//--- icache_refill.sv
`include "ifu_params.svh"

module icache_refill (
  input  logic                      core_clock_i,
  input  logic                      core_reset_i,
  input  logic                      miss_i,
  input  logic [`IFU_PC_W-1:0]      miss_pc_i,
  input  logic                      victim_i,
  input  logic                      icache_flush_i,
  output ifu_pkg::refill_state_t    state_o,
  output ifu_pkg::bus_req_t         bus_req_o,
  input  logic                      bus_ready_i,
  input  ifu_pkg::bus_rsp_t         bus_rsp_i,
  output logic [1:0]                tag_wr_o,
  output logic [`IFU_SET_W-1:0]     tag_wr_set_o,
  output ifu_pkg::tag_entry_t       tag_wr_entry_o,
  output logic                      data_wr_o,
  output logic [`IFU_DATA_AW-1:0]   data_wr_addr_o,
  output logic [`IFU_FETCH_W-1:0]   data_wr_word_o
);

  localparam int LINE_W = `IFU_PC_W - `IFU_OFF_W;

  ifu_pkg::refill_state_t state_q;
  ifu_pkg::refill_state_t state_d;
  // line index of the missing pc, tag above set
  logic [LINE_W-1:0]      line_q;
  logic                   victim_q;
  logic                   req_valid_q;
  logic [`IFU_BEAT_W-1:0] beat_q;
  logic [`IFU_SET_W-1:0]  inv_set_q;
  logic                   beat_acc;
  logic                   fill_done;

  assign beat_acc  = (state_q == ifu_pkg::refill_fill) && bus_rsp_i.valid;
  assign fill_done = beat_acc && bus_rsp_i.last;

  // flush wins over a miss seen in the same cycle
  always_comb begin
    state_d = state_q;
    case (state_q)
      ifu_pkg::refill_idle: begin
        if (icache_flush_i) begin
          state_d = ifu_pkg::refill_inval;
        end else if (miss_i) begin
          state_d = ifu_pkg::refill_fill;
        end
      end
      ifu_pkg::refill_fill: begin
        if (fill_done) begin
          state_d = ifu_pkg::refill_idle;
        end
      end
      ifu_pkg::refill_inval: begin
        if (inv_set_q == `IFU_SET_W'(`IFU_SETS - 1)) begin
          state_d = ifu_pkg::refill_idle;
        end
      end
      default: state_d = ifu_pkg::refill_idle;
    endcase
  end

  // reset starts a full invalidate sweep
  always_ff @(posedge core_clock_i) begin
    if (core_reset_i) begin
      state_q <= ifu_pkg::refill_inval;
    end else begin
      state_q <= state_d;
    end
  end

  // request held until the bus takes it
  always_ff @(posedge core_clock_i) begin
    if (core_reset_i) begin
      req_valid_q <= 1'b0;
    end else if (state_q == ifu_pkg::refill_idle) begin
      req_valid_q <= (state_d == ifu_pkg::refill_fill);
    end else if (state_q == ifu_pkg::refill_fill) begin
      req_valid_q <= req_valid_q & ~bus_ready_i;
    end else begin
      req_valid_q <= 1'b0;
    end
  end

  // capture line and victim way at the miss
  always_ff @(posedge core_clock_i) begin
    if ((state_q == ifu_pkg::refill_idle) && miss_i) begin
      line_q   <= miss_pc_i[`IFU_PC_W-1:`IFU_OFF_W];
      victim_q <= victim_i;
    end
  end

  // beat counter, one step per accepted response
  always_ff @(posedge core_clock_i) begin
    if (core_reset_i) begin
      beat_q <= '0;
    end else if (state_q != ifu_pkg::refill_fill) begin
      beat_q <= '0;
    end else if (bus_rsp_i.valid) begin
      beat_q <= beat_q + 1'b1;
    end
  end

  // set counter for the invalidate sweep
  always_ff @(posedge core_clock_i) begin
    if (core_reset_i) begin
      inv_set_q <= '0;
    end else if (state_q == ifu_pkg::refill_inval) begin
      inv_set_q <= inv_set_q + 1'b1;
    end else begin
      inv_set_q <= '0;
    end
  end

  assign state_o         = state_q;
  assign bus_req_o.valid = req_valid_q;
  // byte address of the line
  assign bus_req_o.addr  = {line_q, {(`IFU_OFF_W + 2){1'b0}}};

  // every beat goes straight into the victim way
  assign data_wr_o      = beat_acc;
  assign data_wr_addr_o = {victim_q, line_q[`IFU_SET_W-1:0], beat_q};
  assign data_wr_word_o = bus_rsp_i.data;

  // tag goes valid with the last beat; sweep clears both ways
  always_comb begin
    tag_wr_o = 2'b00;
    if (state_q == ifu_pkg::refill_inval) begin
      tag_wr_o = 2'b11;
    end else if (fill_done) begin
      tag_wr_o = victim_q ? 2'b10 : 2'b01;
    end
    tag_wr_set_o = (state_q == ifu_pkg::refill_inval) ? inv_set_q : line_q[`IFU_SET_W-1:0];
    tag_wr_entry_o.valid = (state_q == ifu_pkg::refill_fill);
    tag_wr_entry_o.tag   = line_q[LINE_W-1:`IFU_SET_W];
  end

  // bus must not answer unless a fill is in progress
  a_rsp_in_fill: assert property (@(posedge core_clock_i) disable iff (core_reset_i)
    bus_rsp_i.valid |-> state_q == ifu_pkg::refill_fill);

endmodule

//--- ifu_params.svh
`ifndef IFU_PARAMS_SVH
`define IFU_PARAMS_SVH

// word addressed pc, bits [1:0] of the byte address dropped
`define IFU_PC_W 30
// one fetch packet holds two instructions
`define IFU_FETCH_W 64
// total instruction cache capacity in bytes
`define IFU_ICACHE_BYTES 8192
// 64-bit words per cache line
`define IFU_LINE_WORDS 8
// reset fetch address, byte address 0x80
`define IFU_RESET_PC 30'h0000_0020

// sets per way, two ways
`define IFU_SETS (`IFU_ICACHE_BYTES / (`IFU_LINE_WORDS * 8) / 2)
`define IFU_SET_W $clog2(`IFU_SETS)
// instruction offset inside a line
`define IFU_OFF_W $clog2(`IFU_LINE_WORDS * 2)
// beat index inside a line
`define IFU_BEAT_W $clog2(`IFU_LINE_WORDS)
`define IFU_TAG_W (`IFU_PC_W - `IFU_SET_W - `IFU_OFF_W)
// data store address: way, set, beat
`define IFU_DATA_AW (1 + `IFU_SET_W + `IFU_BEAT_W)

`endif

//--- ifu_patterns.txt
// memory image: entry count, then per line a 64-bit word address and its data
// script: entry count, then per line a word pc and the expected 64-bit fetch word
// image count
4
// reset line, word pc 0x20 and 0x24
10 0010011300a00093
12 40208233002081b3
// redirect target line, byte address 0x800
100 0000006f00000013
101 00812423fe010113
// script count
2
// redirect to an odd pc in a new line
201 0000006f00000013
// back into the reset line after a flush
24 40208233002081b3

//--- ifu_pkg.sv
`include "ifu_params.svh"

package ifu_pkg;

  // one tag way entry
  typedef struct packed {
    logic                  valid;
    logic [`IFU_TAG_W-1:0] tag;
  } tag_entry_t;

  // pc handed from the generator to the cache
  typedef struct packed {
    logic                 valid;
    logic [`IFU_PC_W-1:0] pc;
  } fetch_req_t;

  // registered packet towards decode
  typedef struct packed {
    logic                    valid;
    logic [`IFU_PC_W-1:0]    pc;
    logic [`IFU_FETCH_W-1:0] instr;
  } fetch_pkt_t;

  // burst read request, address is line aligned
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
  } bus_req_t;

  // one response beat
  typedef struct packed {
    logic                    valid;
    logic                    last;
    logic [`IFU_FETCH_W-1:0] data;
  } bus_rsp_t;

  typedef enum logic [1:0] {
    refill_idle,
    refill_fill,
    refill_inval
  } refill_state_t;

endpackage

//--- ifu_top.sv
`include "ifu_params.svh"

module ifu_top (
  input  logic                 core_clock_i,
  input  logic                 core_reset_i,
  // redirect from the core
  input  logic                 redirect_i,
  input  logic [`IFU_PC_W-1:0] redirect_pc_i,
  // decode side
  input  logic                 decode_stall_i,
  output ifu_pkg::fetch_pkt_t  fetch_pkt_o,
  // cache maintenance
  input  logic                 icache_flush_i,
  output logic                 flush_idle_o,
  input  logic                 victim_bit_i,
  // burst read bus
  output ifu_pkg::bus_req_t    bus_req_o,
  input  logic                 bus_ready_i,
  input  ifu_pkg::bus_rsp_t    bus_rsp_i
);

  ifu_pkg::fetch_req_t fetch_req;
  logic                icache_busy;

  fetch_pc_gen u_pc_gen (
    .core_clock_i (core_clock_i),
    .core_reset_i (core_reset_i),
    .redirect_i   (redirect_i),
    .redirect_pc_i(redirect_pc_i),
    .busy_i       (icache_busy),
    .fetch_req_o  (fetch_req)
  );

  icache u_icache (
    .core_clock_i  (core_clock_i),
    .core_reset_i  (core_reset_i),
    .fetch_req_i   (fetch_req),
    .decode_stall_i(decode_stall_i),
    .busy_o        (icache_busy),
    .fetch_pkt_o   (fetch_pkt_o),
    .icache_flush_i(icache_flush_i),
    .flush_idle_o  (flush_idle_o),
    .victim_bit_i  (victim_bit_i),
    .bus_req_o     (bus_req_o),
    .bus_ready_i   (bus_ready_i),
    .bus_rsp_i     (bus_rsp_i)
  );

endmodule

//--- tb_ifu.sv
`include "ifu_params.svh"

module tb_ifu;

  localparam int clk_period   = 40;
  localparam int drive_dly    = 5;
  localparam int reset_cycles = 4;
  // two counts plus address and value pairs in the pattern file
  localparam int pat_words    = 14;
  localparam int max_entries  = 8;
  localparam int max_delay    = 3;
  localparam int max_gap      = 3;
  localparam int stall_cycles = 6;
  // worst refill covers the accept delay, eight gapped beats and the return to idle
  localparam int refill_cycles = max_delay + `IFU_LINE_WORDS * (max_gap + 1) + 4;

  logic                 core_clock;
  logic                 core_reset;
  logic                 redirect;
  logic [`IFU_PC_W-1:0] redirect_pc;
  logic                 decode_stall;
  ifu_pkg::fetch_pkt_t  fetch_pkt;
  logic                 icache_flush;
  logic                 flush_idle;
  logic                 victim_bit;
  ifu_pkg::bus_req_t    bus_req;
  logic                 bus_ready;
  ifu_pkg::bus_rsp_t    bus_rsp;

  // memory image and script from the pattern file
  logic [63:0]          pat [pat_words];
  logic [31:0]          img_addr [max_entries];
  logic [63:0]          img_data [max_entries];
  logic [`IFU_PC_W-1:0] scr_pc [max_entries];
  logic [63:0]          scr_instr [max_entries];
  int                   img_n;
  int                   scr_n;
  bit                   loaded;
  integer               seed = 36516;

  int                   err_count;
  int                   check_count;
  int                   test_errs;
  int                   pass_tests;
  int                   fail_tests;
  // observed traffic
  int                   req_count;
  logic [31:0]          last_req_addr;
  logic                 req_prev;
  int                   pkt_count;
  ifu_pkg::fetch_pkt_t  last_pkt;
  logic [`IFU_PC_W-1:0] expect_pc;
  bit                   pc_known;

  ifu_top dut0 (
    .core_clock_i  (core_clock),
    .core_reset_i  (core_reset),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .decode_stall_i(decode_stall),
    .fetch_pkt_o   (fetch_pkt),
    .icache_flush_i(icache_flush),
    .flush_idle_o  (flush_idle),
    .victim_bit_i  (victim_bit),
    .bus_req_o     (bus_req),
    .bus_ready_i   (bus_ready),
    .bus_rsp_i     (bus_rsp)
  );

  initial begin : clock_gen
    core_clock = 1'b0;
    forever #(clk_period / 2) core_clock = ~core_clock;
  end

  // image words from the file and an address based fill elsewhere
  function automatic logic [63:0] image_word(input logic [31:0] waddr);
    logic [63:0] word;
    word = {waddr ^ 32'ha5c3_0000, ~waddr};
    for (int i = 0; i < img_n; i++) begin
      if (img_addr[i] == waddr) begin
        word = img_data[i];
      end
    end
    return word;
  endfunction

  // byte address of the 64-byte line holding a word pc
  function automatic logic [31:0] line_addr(input logic [`IFU_PC_W-1:0] pc);
    logic [31:0] byte_addr;
    byte_addr = {pc, 2'b00};
    return byte_addr & ~32'(`IFU_LINE_WORDS * 8 - 1);
  endfunction

  task automatic load_patterns();
    int idx;
    $readmemh("ifu_patterns.txt", pat);
    img_n = int'(pat[0]);
    for (int i = 0; i < img_n; i++) begin
      img_addr[i] = pat[1 + 2 * i][31:0];
      img_data[i] = pat[2 + 2 * i];
    end
    idx   = 1 + 2 * img_n;
    scr_n = int'(pat[idx]);
    for (int i = 0; i < scr_n; i++) begin
      scr_pc[i]    = pat[idx + 1 + 2 * i][`IFU_PC_W-1:0];
      scr_instr[i] = pat[idx + 2 + 2 * i];
    end
    loaded = 1'b1;
  endtask

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    check_count++;
    assert (got === exp) else begin
      $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
      err_count++;
      test_errs++;
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errs == 0) begin
      pass_tests++;
      $display("test %s ok, %0d packets, %0d requests so far", name, pkt_count, req_count);
    end else begin
      fail_tests++;
      $display("test %s failed with %0d errors", name, test_errs);
    end
    test_errs = 0;
  endtask

  // step one clock and sample the registered outputs
  task automatic next_cycle();
    bit                   loading;
    logic [`IFU_PC_W-1:0] cur_pc;
    logic [`IFU_PC_W-1:0] step;
    loading = !decode_stall;
    @(posedge core_clock);
    #drive_dly;
    // a request counts once on its rising valid
    if (bus_req.valid && !req_prev) begin
      req_count++;
      last_req_addr = bus_req.addr;
    end
    req_prev = bus_req.valid;
    if (loading && fetch_pkt.valid) begin
      pkt_count++;
      last_pkt = fetch_pkt;
      if (pc_known) begin
        compare_value("fetch_pkt_o.pc", 64'(fetch_pkt.pc), 64'(expect_pc));
        cur_pc = expect_pc;
      end else begin
        cur_pc = fetch_pkt.pc;
      end
      compare_value("fetch_pkt_o.instr", fetch_pkt.instr, image_word(32'(cur_pc >> 1)));
      // two instructions per fetch or one from an odd word
      step      = cur_pc[0] ? `IFU_PC_W'd1 : `IFU_PC_W'd2;
      expect_pc = cur_pc + step;
      pc_known  = 1'b1;
    end
  endtask

  task automatic wait_idle();
    while (!flush_idle) begin
      next_cycle();
    end
  endtask

  // redirect only in idle so the old refill is not in the way
  task automatic redirect_to(input logic [`IFU_PC_W-1:0] pc);
    wait_idle();
    redirect    = 1'b1;
    redirect_pc = pc;
    expect_pc   = pc;
    pc_known    = 1'b1;
    next_cycle();
    redirect    = 1'b0;
  endtask

  // jump to a script pc and expect one refill and its word
  task automatic refetch_entry(input int idx);
    int reqs_before;
    int pkts_before;
    redirect_to(scr_pc[idx]);
    reqs_before = req_count;
    pkts_before = pkt_count;
    while (pkt_count == pkts_before) begin
      next_cycle();
    end
    compare_value("fetch_pkt_o.instr", last_pkt.instr, scr_instr[idx]);
    compare_value("request count", 64'(req_count - reqs_before), 64'd1);
    compare_value("bus_req_o.addr", 64'(last_req_addr), 64'(line_addr(scr_pc[idx])));
  endtask

  // burst memory with a random accept delay and randomly gapped beats
  initial begin : bus_model
    int          delay;
    int          gap;
    logic [31:0] base;
    bus_ready  = 1'b0;
    bus_rsp    = '0;
    victim_bit = 1'b0;
    forever begin
      @(posedge core_clock);
      #drive_dly;
      if (bus_req.valid) begin
        delay = $unsigned($random(seed)) % (max_delay + 1);
        repeat (delay) begin
          @(posedge core_clock);
          #drive_dly;
        end
        base      = bus_req.addr;
        bus_ready = 1'b1;
        @(posedge core_clock);
        #drive_dly;
        bus_ready = 1'b0;
        for (int beat = 0; beat < `IFU_LINE_WORDS; beat++) begin
          gap = $unsigned($random(seed)) % (max_gap + 1);
          repeat (gap) begin
            @(posedge core_clock);
            #drive_dly;
          end
          bus_rsp.valid = 1'b1;
          bus_rsp.last  = (beat == `IFU_LINE_WORDS - 1);
          bus_rsp.data  = image_word((base >> 3) + 32'(beat));
          @(posedge core_clock);
          #drive_dly;
          bus_rsp = '0;
        end
        victim_bit = 1'($random(seed));
      end
    end
  end

  initial begin : watchdog
    int limit;
    wait (loaded);
    // per script entry room for a flush sweep plus several stream refills
    limit = (scr_n + 1) * (`IFU_SETS + 8 * refill_cycles);
    repeat (limit) @(posedge core_clock);
    $display("watchdog: the run did not finish within %0d cycles", limit);
    $display("** FAIL **");
    $finish;
  end

  initial begin : main
    ifu_pkg::fetch_pkt_t  held;
    logic [`IFU_PC_W-1:0] line_last;
    int                   sweep;
    core_reset   = 1'b1;
    redirect     = 1'b0;
    redirect_pc  = '0;
    decode_stall = 1'b0;
    icache_flush = 1'b0;
    req_prev     = 1'b0;
    last_pkt     = '0;
    load_patterns();
    repeat (reset_cycles) next_cycle();
    core_reset = 1'b0;
    expect_pc  = `IFU_RESET_PC;
    pc_known   = 1'b1;

    // first miss after the reset sweep
    while (req_count == 0) begin
      next_cycle();
    end
    compare_value("bus_req_o.addr", 64'(last_req_addr), 64'(line_addr(`IFU_RESET_PC)));
    while (pkt_count < 2) begin
      next_cycle();
    end
    compare_value("fetch_pkt_o.pc", 64'(last_pkt.pc), 64'(`IFU_RESET_PC) + 64'd2);
    finish_test("reset_fetch");

    // rest of the reset line hits without a new request
    line_last = `IFU_PC_W'((line_addr(`IFU_RESET_PC) >> 2) + 32'(`IFU_LINE_WORDS * 2 - 2));
    while (last_pkt.pc != line_last) begin
      next_cycle();
    end
    compare_value("request count", 64'(req_count), 64'd1);
    compare_value("packet count", 64'(pkt_count), 64'(`IFU_LINE_WORDS));
    finish_test("line_hits");

    refetch_entry(0);
    sweep = pkt_count + 3;
    while (pkt_count < sweep) begin
      next_cycle();
    end
    finish_test("redirect");

    held         = fetch_pkt;
    decode_stall = 1'b1;
    repeat (stall_cycles) begin
      next_cycle();
      compare_value("fetch_pkt_o.valid", 64'(fetch_pkt.valid), 64'(held.valid));
      compare_value("fetch_pkt_o.pc", 64'(fetch_pkt.pc), 64'(held.pc));
      compare_value("fetch_pkt_o.instr", fetch_pkt.instr, held.instr);
    end
    // pc kept stepping under the stall so resync on the next packet
    pc_known     = 1'b0;
    decode_stall = 1'b0;
    sweep        = pkt_count;
    while (pkt_count == sweep) begin
      next_cycle();
    end
    finish_test("decode_stall");

    wait_idle();
    icache_flush = 1'b1;
    sweep        = 0;
    do begin
      next_cycle();
      if (!flush_idle) begin
        sweep++;
      end
    end while (!flush_idle);
    icache_flush = 1'b0;
    compare_value("flush sweep cycles", 64'(sweep), 64'(`IFU_SETS));
    refetch_entry(1);
    finish_test("flush_refetch");

    $display("tests %0d passed, %0d failed, %0d checks, %0d errors",
             pass_tests, fail_tests, check_count, err_count);
    if (err_count == 0 && fail_tests == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
